//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_shuffle_unit
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) shuffle_params.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- beat_counter.sv
// Beat counter of the read shuffler
// Counts stage-0 transfers within the current burst and flags the
// last beat, then wraps to zero

`timescale 1ns/1ps

`include "shuffle_params.svh"

module beat_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fire_i,
  input  logic [`SHUF_LEN_W-1:0] head_len_i,
  output logic                   last_o
);

  logic [`SHUF_LEN_W-1:0] count_q;
  logic [`SHUF_LEN_W-1:0] last_idx;

  // Index of the final beat of the burst at the head
  assign last_idx = head_len_i - 1'b1;
  assign last_o   = (count_q == last_idx);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (fire_i) begin
      if (last_o) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

//--- burst_tracker.sv
// Queue of accepted bursts for the read shuffler
// Accept pointer, one issue pointer per stage, occupancy count and
// the count of bursts still waiting for stage 0

`timescale 1ns/1ps

`include "shuffle_params.svh"

module burst_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Request channel
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  shuffle_pkg::burst_req_t req_i,
  // Stage side
  input  shuffle_pkg::stage_en_t  last_fire_i,
  output shuffle_pkg::stage_en_t  stage_en_o,
  output logic [`SHUF_LEN_W-1:0]  head_len_o,
  output logic                    head_valid_o
);

  localparam int unsigned LAST_STAGE = `SHUF_NUM_STAGES - 1;

  typedef logic [$clog2(`SHUF_NUM_TRACKERS):0] cnt_t;

  shuffle_pkg::trk_entry_t [`SHUF_NUM_TRACKERS-1:0] queue_q;
  shuffle_pkg::trk_ptr_t                            accept_ptr_q;
  shuffle_pkg::trk_ptr_t [`SHUF_NUM_STAGES-1:0]     issue_ptr_q;
  cnt_t                                             occ_q;
  cnt_t                                             pend_q;

  logic                   req_fire;
  logic                   free;
  shuffle_pkg::stage_en_t new_en;

  function automatic shuffle_pkg::trk_ptr_t next_ptr(input shuffle_pkg::trk_ptr_t ptr);
    if (ptr == shuffle_pkg::trk_ptr_t'(`SHUF_NUM_TRACKERS - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Accept and free
  ////////////////////////////////////////////////////////////////////////////

  assign req_ready_o = (occ_q != cnt_t'(`SHUF_NUM_TRACKERS));
  assign req_fire    = req_valid_i & req_ready_o;

  // The final stage finishing a burst releases its entry
  assign free = last_fire_i[LAST_STAGE];

  // Stages at or above the element width do the shuffling
  always_comb begin
    for (int s = 0; s < `SHUF_NUM_STAGES; s++) begin
      new_en[s] = (s >= int'(req_i.ew));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      queue_q      <= '0;
      accept_ptr_q <= '0;
      issue_ptr_q  <= '0;
      occ_q        <= '0;
      pend_q       <= '0;
    end else begin
      if (req_fire) begin
        queue_q[accept_ptr_q].len      <= req_i.len;
        queue_q[accept_ptr_q].stage_en <= new_en;
        accept_ptr_q                   <= next_ptr(accept_ptr_q);
      end
      // Each stage moves on to the next burst after its own last beat
      for (int s = 0; s < `SHUF_NUM_STAGES; s++) begin
        if (last_fire_i[s]) begin
          issue_ptr_q[s] <= next_ptr(issue_ptr_q[s]);
        end
      end
      occ_q  <= occ_q + cnt_t'(req_fire) - cnt_t'(free);
      pend_q <= pend_q + cnt_t'(req_fire) - cnt_t'(last_fire_i[0]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-stage view of the queue
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int s = 0; s < `SHUF_NUM_STAGES; s++) begin
      stage_en_o[s] = queue_q[issue_ptr_q[s]].stage_en[s];
    end
  end

  assign head_len_o   = queue_q[issue_ptr_q[0]].len;
  // Something accepted that stage 0 has not finished yet
  assign head_valid_o = (pend_q != '0);

endmodule

//--- shuffle_network.sv
// One permutation stage of the read shuffler
// Interleaves the two halves of the beat at the block size of the stage,
// or copies the beat when disabled

`timescale 1ns/1ps

`include "shuffle_params.svh"

module shuffle_network #(
  parameter int unsigned STAGE = 0
) (
  input  shuffle_pkg::beat_t beat_i,
  input  logic               enable_i,
  output shuffle_pkg::beat_t beat_o
);

  // Block size starts at one byte per lane and doubles every stage
  localparam int unsigned BLOCK_W    = (8 * `SHUF_NR_LANES) << STAGE;
  localparam int unsigned ITERATIONS = `SHUF_TOTAL_DW / (2 * BLOCK_W);

  ////////////////////////////////////////////////////////////////////////////
  // Block permutation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    beat_o = beat_i;
    if (enable_i) begin
      // Block i of the lower half and block i of the upper half
      // become neighbours at the output
      for (int i = 0; i < ITERATIONS; i++) begin
        for (int j = 0; j < 2; j++) begin
          beat_o.data[(2 * i + j) * BLOCK_W +: BLOCK_W] =
            beat_i.data[(j * ITERATIONS + i) * BLOCK_W +: BLOCK_W];
        end
      end
    end
  end

endmodule

//--- shuffle_params.svh
// Build-time sizes of the read shuffler
// Lane and cluster geometry, beat width, stage count, burst queue depth
// and the width of the beat count

`ifndef SHUFFLE_PARAMS_SVH
`define SHUFFLE_PARAMS_SVH

// Cluster geometry
`define SHUF_NR_LANES      2
`define SHUF_NR_CLUSTERS   4
`define SHUF_CLUSTER_DW    64
`define SHUF_TOTAL_DW      (`SHUF_NR_CLUSTERS * `SHUF_CLUSTER_DW)

// One stage per doubling of the block size, from 8 bits per lane up to a slice
`define SHUF_NUM_STAGES    ($clog2(`SHUF_CLUSTER_DW / (8 * `SHUF_NR_LANES)))

// Burst bookkeeping
`define SHUF_NUM_TRACKERS  4
`define SHUF_LEN_W         8

`endif

//--- shuffle_pipe_reg.sv
// One-entry valid/ready register for beats
// Separates two permutation stages and holds its beat under
// back-pressure, ready passes through when empty or draining

`timescale 1ns/1ps

module shuffle_pipe_reg (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Upstream side
  input  logic               valid_i,
  output logic               ready_o,
  input  shuffle_pkg::beat_t beat_i,
  // Downstream side
  output logic               valid_o,
  input  logic               ready_i,
  output shuffle_pkg::beat_t beat_o
);

  logic               valid_q;
  shuffle_pkg::beat_t beat_q;

  // Can take a new beat if empty or the held one leaves this cycle
  assign ready_o = ~valid_q | ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on an upstream transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      beat_q <= beat_i;
    end
  end

  assign valid_o = valid_q;
  assign beat_o  = beat_q;

endmodule

//--- shuffle_pkg.sv
// Types shared by the read shuffler
// Element-width code, beat, burst request, stage enables,
// queue pointer and queue entry

`include "shuffle_params.svh"

package shuffle_pkg;

  // Element width code: 0 = 8 bit, 1 = 16 bit, 2 = 32 bit, 3 = 64 bit
  typedef logic [1:0] ew_t;

  // One wide memory beat, one slice per cluster, plus the burst end marker
  typedef struct packed {
    logic [`SHUF_TOTAL_DW-1:0] data;
    logic                      last;
  } beat_t;

  // Burst request, len is the number of beats
  typedef struct packed {
    logic [`SHUF_LEN_W-1:0] len;
    ew_t                    ew;
  } burst_req_t;

  typedef logic [`SHUF_NUM_STAGES-1:0] stage_en_t;

  typedef logic [$clog2(`SHUF_NUM_TRACKERS)-1:0] trk_ptr_t;

  // What the stages need to know about a queued burst
  typedef struct packed {
    logic [`SHUF_LEN_W-1:0] len;
    stage_en_t              stage_en;
  } trk_entry_t;

endpackage

//--- shuffle_unit.sv
// Top level of the read shuffler
// Burst tracker, beat counter, two permutation stages and the
// register between them

`timescale 1ns/1ps

`include "shuffle_params.svh"

module shuffle_unit (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Burst requests
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  shuffle_pkg::burst_req_t     req_i,
  // Input beats, data only
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic [`SHUF_TOTAL_DW-1:0]   in_data_i,
  // Shuffled beats
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output shuffle_pkg::beat_t          out_beat_o
);

  localparam int unsigned LAST_STAGE = `SHUF_NUM_STAGES - 1;

  shuffle_pkg::stage_en_t stage_en;
  shuffle_pkg::stage_en_t last_fire;
  logic [`SHUF_LEN_W-1:0] head_len;
  logic                   head_valid;
  logic                   cnt_last;

  shuffle_pkg::beat_t s0_in;
  shuffle_pkg::beat_t s0_out;
  shuffle_pkg::beat_t reg_beat;
  logic               s0_valid;
  logic               s0_fire;
  logic               reg_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  burst_tracker u_burst_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .last_fire_i  (last_fire),
    .stage_en_o   (stage_en),
    .head_len_o   (head_len),
    .head_valid_o (head_valid)
  );

  beat_counter u_beat_counter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .fire_i     (s0_fire),
    .head_len_i (head_len),
    .last_o     (cnt_last)
  );

  // Beats are only taken while a burst is waiting for them
  assign s0_valid   = in_valid_i & head_valid;
  assign in_ready_o = reg_ready & head_valid;
  assign s0_fire    = in_valid_i & in_ready_o;

  assign last_fire[0]          = s0_fire & s0_out.last;
  assign last_fire[LAST_STAGE] = out_valid_o & out_ready_i & out_beat_o.last;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  assign s0_in.data = in_data_i;
  assign s0_in.last = cnt_last;

  shuffle_network #(
    .STAGE (0)
  ) u_stage0 (
    .beat_i   (s0_in),
    .enable_i (stage_en[0]),
    .beat_o   (s0_out)
  );

  shuffle_pipe_reg u_pipe_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (s0_valid),
    .ready_o (reg_ready),
    .beat_i  (s0_out),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .beat_o  (reg_beat)
  );

  // Final stage sits after the register, combinational to the output
  shuffle_network #(
    .STAGE (LAST_STAGE)
  ) u_stage1 (
    .beat_i   (reg_beat),
    .enable_i (stage_en[LAST_STAGE]),
    .beat_o   (out_beat_o)
  );

endmodule

//--- tb_shuffle_unit.sv
// Directed testbench for the read shuffler
// Reference permutation model, xorshift data, beat and request drivers,
// output monitor with a queue of expected beats, and a watchdog

`timescale 1ns/1ps

`include "shuffle_params.svh"

module tb_shuffle_unit;

  localparam logic [31:0] SEED           = 32'h9125_0a37;
  localparam int          TOTAL_BEATS    = 48;
  localparam int          TIMEOUT_CYCLES = TOTAL_BEATS * 40 + 500;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        req_valid_i;
  logic                        req_ready_o;
  shuffle_pkg::burst_req_t     req_i;
  logic                        in_valid_i;
  logic                        in_ready_o;
  logic [`SHUF_TOTAL_DW-1:0]   in_data_i;
  logic                        out_valid_o;
  logic                        out_ready_i;
  shuffle_pkg::beat_t          out_beat_o;

  shuffle_pkg::beat_t exp_q[$];
  int                 errors;
  logic [31:0]        data_state;
  logic [31:0]        stall_state;
  logic               stall_en;
  logic               held_valid;
  shuffle_pkg::beat_t held_beat;

  shuffle_unit u_shuffle_unit (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_beat_o  (out_beat_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and random data
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] r;
    r = x ^ (x << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  // Output block 2i+j takes input block j*iters+i, done bit by bit
  function automatic logic [`SHUF_TOTAL_DW-1:0] permute_stage(
    input logic [`SHUF_TOTAL_DW-1:0] d, input int stage);
    int                        bw;
    int                        iters;
    logic [`SHUF_TOTAL_DW-1:0] r;
    bw    = 16 << stage;
    iters = `SHUF_TOTAL_DW / (2 * bw);
    r     = d;
    for (int i = 0; i < iters; i++) begin
      for (int j = 0; j < 2; j++) begin
        for (int b = 0; b < bw; b++) begin
          r[(2 * i + j) * bw + b] = d[(j * iters + i) * bw + b];
        end
      end
    end
    return r;
  endfunction

  function automatic logic [`SHUF_TOTAL_DW-1:0] expected_data(
    input logic [`SHUF_TOTAL_DW-1:0] d, input shuffle_pkg::ew_t ew);
    logic [`SHUF_TOTAL_DW-1:0] r;
    r = d;
    for (int s = 0; s < 2; s++) begin
      if (s >= int'(ew)) begin
        r = permute_stage(r, s);
      end
    end
    return r;
  endfunction

  task automatic next_data(output logic [`SHUF_TOTAL_DW-1:0] d);
    for (int k = 0; k < `SHUF_TOTAL_DW / 32; k++) begin
      data_state    = xorshift32(data_state);
      d[k*32 +: 32] = data_state;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drivers, all start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_req(input int len, input shuffle_pkg::ew_t ew);
    req_valid_i = 1'b1;
    req_i.len   = `SHUF_LEN_W'(len);
    req_i.ew    = ew;
    do @(posedge clk_i); while (!req_ready_o);
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_beats(input int n, input shuffle_pkg::ew_t ew);
    logic [`SHUF_TOTAL_DW-1:0] d;
    shuffle_pkg::beat_t        e;
    for (int i = 0; i < n; i++) begin
      next_data(d);
      e.data = expected_data(d, ew);
      e.last = (i == n - 1);
      exp_q.push_back(e);
      in_valid_i = 1'b1;
      in_data_i  = d;
      do @(posedge clk_i); while (!in_ready_o);
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    do @(negedge clk_i); while (exp_q.size() != 0);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errors++;
      $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output side: ready stalls and monitor
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    out_ready_i = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      stall_state = xorshift32(stall_state);
      out_ready_i = stall_en ? stall_state[4] : 1'b1;
    end
  end

  always @(posedge clk_i) begin
    shuffle_pkg::beat_t e;
    if (held_valid) begin
      assert (out_valid_o) else begin
        errors++;
        $display("Output valid dropped at %0t while a beat was held", $time);
      end
      assert (out_beat_o === held_beat) else begin
        errors++;
        $display("error at %0t: out_beat_o got %h expected %h", $time, out_beat_o, held_beat);
      end
    end
    held_valid = out_valid_o & ~out_ready_i;
    held_beat  = out_beat_o;
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected output beat at %0t", $time);
      end else begin
        e = exp_q.pop_front();
        assert (out_beat_o.data === e.data) else begin
          errors++;
          $display("error at %0t: out_beat_o.data got %h expected %h",
                   $time, out_beat_o.data, e.data);
        end
        check_bit("out_beat_o.last", out_beat_o.last, e.last);
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Watchdog expired, the tests did not complete. Errors: %0d", errors + 1);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_full_shuffle();
    send_req(4, 2'd0);
    send_beats(4, 2'd0);
    wait_drain();
  endtask

  task automatic test_partial_shuffle();
    send_req(3, 2'd1);
    send_beats(3, 2'd1);
    send_req(2, 2'd2);
    send_beats(2, 2'd2);
    send_req(3, 2'd3);
    send_beats(3, 2'd3);
    wait_drain();
  endtask

  task automatic test_output_stalls();
    stall_en = 1'b1;
    send_req(16, 2'd0);
    send_beats(16, 2'd0);
    wait_drain();
    stall_en = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic test_queue_full();
    for (int k = 0; k < 4; k++) begin
      send_req(2, shuffle_pkg::ew_t'(k));
    end
    check_bit("req_ready_o", req_ready_o, 1'b0);
    send_beats(2, 2'd0);
    wait_drain();
    check_bit("req_ready_o", req_ready_o, 1'b1);
    for (int k = 1; k < 4; k++) begin
      send_beats(2, shuffle_pkg::ew_t'(k));
    end
    wait_drain();
  endtask

  // Burst tails overlap with the next burst in stage 0
  task automatic test_back_to_back();
    send_req(3, 2'd0);
    send_req(5, 2'd2);
    send_req(4, 2'd1);
    send_beats(3, 2'd0);
    send_beats(5, 2'd2);
    send_beats(4, 2'd1);
    wait_drain();
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    errors      = 0;
    data_state  = SEED;
    stall_state = xorshift32(SEED);
    stall_en    = 1'b0;
    held_valid  = 1'b0;
    held_beat   = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b0);
    check_bit("req_ready_o", req_ready_o, 1'b1);
    test_full_shuffle();
    test_partial_shuffle();
    test_output_stalls();
    test_queue_full();
    test_back_to_back();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
shuffle_pkg.sv
shuffle_network.sv
shuffle_pipe_reg.sv
burst_tracker.sv
beat_counter.sv
shuffle_unit.sv
tb_shuffle_unit.sv
